// ==== project.f ====
design/adam_bus_pkg.sv
design/adam_ctrl_pkg.sv
design/adam_axil_ram.sv
design/adam_mem_demux.sv
design/adam_pause_ctrl.sv
design/adam_mem_sys.sv
dv/adam_mem_sys_tb.sv

// ==== dv/adam_mem_sys_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module adam_mem_sys_tb;

    import adam_bus_pkg::*;

    localparam int NO_MEMS   = 3;
    localparam int MEM_DEPTH = 256;
    localparam int TIMEOUT   = 100;
    localparam int SWEEP_OFF = 32;

    logic     clk;
    logic     rst_n;
    logic     bus_req_valid;
    bus_req_t bus_req;
    logic     bus_ack;
    bus_rsp_t bus_rsp;
    logic     pause_req;
    logic     pause_ack;

    // Expected memory contents by byte address.
    logic [DATA_WIDTH-1:0] model_mem [int unsigned];
    int                    errors;
    int                    checks;
    integer                seed;

    adam_mem_sys #(
        .NO_MEMS   (NO_MEMS),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_adam_mem_sys (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_ack       (bus_ack),
        .bus_rsp       (bus_rsp),
        .pause_req     (pause_req),
        .pause_ack     (pause_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] mem_addr(input int mem, input int off);
        return (32'(mem) << MEM_SEL_LSB) | (32'(off) << 2);
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] wstrb);
        logic [31:0] word;
        word = model_mem.exists(addr) ? model_mem[addr] : 'x;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (wstrb[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        model_mem[addr] = word;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        return model_mem.exists(addr) ? model_mem[addr] : 'x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("%-16s %s (%0d errors)", name, (errors == start) ? "ok" : "bad", errors - start);
    endtask

    task automatic apply_reset();
        rst_n         = 1'b0;
        bus_req_valid = 1'b0;
        bus_req       = '0;
        pause_req     = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic wait_bus_ack(input logic level);
        int cnt;
        cnt = 0;
        while (bus_ack !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (bus_ack !== level) begin
            $display("Timed out waiting for bus_ack to go to %0b.", level);
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    task automatic wait_pause_ack(input logic level);
        int cnt;
        cnt = 0;
        while (pause_ack !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (pause_ack !== level) begin
            $display("Timed out waiting for pause_ack to go to %0b.", level);
            $display("*** FAILED ***");
            $finish;
        end
    endtask

    task automatic start_access(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        @(negedge clk);
        bus_req       = '{addr: addr, wdata: wdata, wstrb: wstrb, write: write};
        bus_req_valid = 1'b1;
    endtask

    task automatic end_access(output bus_rsp_t rsp);
        rsp           = bus_rsp;
        bus_req_valid = 1'b0;
        wait_bus_ack(1'b0);
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output bus_rsp_t rsp);
        start_access(addr, write, wdata, wstrb);
        wait_bus_ack(1'b1);
        end_access(rsp);
    endtask

    task automatic set_pause(input logic level);
        @(negedge clk);
        pause_req = level;
        wait_pause_ack(level);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input string name);
        bus_rsp_t rsp;
        bus_access(addr, 1'b1, wdata, wstrb, rsp);
        model_write(addr, wdata, wstrb);
        check_value({name, " err"}, 32'd0, 32'(rsp.err));
    endtask

    task automatic read_check(input logic [31:0] addr, input string name);
        bus_rsp_t rsp;
        bus_access(addr, 1'b0, '0, '0, rsp);
        check_value({name, " err"}, 32'd0, 32'(rsp.err));
        check_value({name, " rdata"}, model_read(addr), rsp.rdata);
    endtask

    task automatic test_mem_separation();
        int start;
        start = errors;
        // All RAMs get the same offset before any read back.
        for (int m = 0; m < NO_MEMS; m++) begin
            write_word(mem_addr(m, 5), $random(seed), 4'hf, "separation write");
        end
        for (int m = 0; m < NO_MEMS; m++) begin
            read_check(mem_addr(m, 5), "separation read");
        end
        report_test("mem_separation", start);
    endtask

    task automatic test_byte_strobes();
        logic [3:0] strobes [5];
        int         start;
        start   = errors;
        strobes = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
        write_word(mem_addr(1, 10), 32'h1122_3344, 4'hf, "strobe init");
        for (int i = 0; i < 5; i++) begin
            write_word(mem_addr(1, 10), $random(seed), strobes[i], "strobe write");
            read_check(mem_addr(1, 10), "strobe read");
        end
        report_test("byte_strobes", start);
    endtask

    task automatic test_decode_error();
        logic [31:0] bad [3];
        bus_rsp_t    rsp;
        int          start;
        start = errors;
        bad   = '{mem_addr(NO_MEMS, 0), mem_addr(NO_MEMS + 5, 3), mem_addr(0, MEM_DEPTH)};
        for (int i = 0; i < 3; i++) begin
            bus_access(bad[i], i[0], $random(seed), 4'hf, rsp);
            check_value("decode err", 32'd1, 32'(rsp.err));
            check_value("decode rdata", 32'd0, rsp.rdata);
        end
        write_word(mem_addr(2, 7), $random(seed), 4'hf, "decode recover write");
        read_check(mem_addr(2, 7), "decode recover read");
        report_test("decode_error", start);
    endtask

    task automatic test_pause();
        bus_rsp_t rsp;
        logic     seen;
        int       start;
        start = errors;
        write_word(mem_addr(0, 20), 32'hcafe_f00d, 4'hf, "pause setup");
        set_pause(1'b1);
        start_access(mem_addr(0, 20), 1'b0, '0, '0);
        seen = 1'b0;
        for (int cnt = 0; cnt < 20; cnt++) begin
            @(negedge clk);
            seen = seen | bus_ack;
        end
        checks++;
        assert (!seen) else begin
            $display("An access was acknowledged while the memories were paused.");
            errors++;
        end
        set_pause(1'b0);
        wait_bus_ack(1'b1);
        end_access(rsp);
        check_value("pause pending err", 32'd0, 32'(rsp.err));
        check_value("pause pending rdata", model_read(mem_addr(0, 20)), rsp.rdata);
        report_test("pause", start);
    endtask

    task automatic test_random_sweep();
        logic [31:0] addr;
        logic [3:0]  strb;
        logic        wr;
        int          start;
        start = errors;
        // Both acks are high and both requests held when reset hits.
        set_pause(1'b1);
        start_access(mem_addr(NO_MEMS, 0), 1'b0, '0, '0);
        wait_bus_ack(1'b1);
        rst_n = 1'b0;
        @(negedge clk);
        check_value("reset bus_ack", 32'd0, 32'(bus_ack));
        check_value("reset pause_ack", 32'd0, 32'(pause_ack));
        apply_reset();
        for (int m = 0; m < NO_MEMS; m++) begin
            for (int off = 0; off < SWEEP_OFF; off++) begin
                write_word(mem_addr(m, off), $random(seed), 4'hf, "sweep init");
            end
        end
        for (int i = 0; i < 200; i++) begin
            addr = mem_addr($unsigned($random(seed)) % NO_MEMS,
                            $unsigned($random(seed)) % SWEEP_OFF);
            strb = $random(seed);
            wr   = $random(seed);
            if (wr) begin
                write_word(addr, $random(seed), strb, "sweep write");
            end else begin
                read_check(addr, "sweep read");
            end
        end
        report_test("random_sweep", start);
    endtask

    initial begin
        seed   = 5995;
        errors = 0;
        checks = 0;
        apply_reset();
        test_mem_separation();
        test_byte_strobes();
        test_decode_error();
        test_pause();
        test_random_sweep();
        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/adam_mem_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module adam_mem_sys #(
    parameter int NO_MEMS   = 3,
    parameter int MEM_DEPTH = 256
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   bus_req_valid,
    input  wire adam_bus_pkg::bus_req_t bus_req,
    output logic                        bus_ack,
    output adam_bus_pkg::bus_rsp_t      bus_rsp,

    input  wire logic                   pause_req,
    output logic                        pause_ack
);

    import adam_bus_pkg::*;

    logic     mem_req       [NO_MEMS];
    bus_req_t mem_bus_req;
    logic     mem_ack       [NO_MEMS];
    bus_rsp_t mem_bus_rsp   [NO_MEMS];
    logic     mem_pause_req [NO_MEMS];
    logic     mem_pause_ack [NO_MEMS];

    adam_mem_demux #(
        .NO_MEMS   (NO_MEMS),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem_demux (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (bus_req_valid),
        .bus_req     (bus_req),
        .ack         (bus_ack),
        .bus_rsp     (bus_rsp),
        .mem_req     (mem_req),
        .mem_bus_req (mem_bus_req),
        .mem_ack     (mem_ack),
        .mem_bus_rsp (mem_bus_rsp)
    );

    adam_pause_ctrl #(
        .NO_MEMS (NO_MEMS)
    ) u_pause_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .pause_req     (pause_req),
        .pause_ack     (pause_ack),
        .mem_pause_req (mem_pause_req),
        .mem_pause_ack (mem_pause_ack)
    );

    // All RAMs share the request payload, only req is per RAM.
    for (genvar i = 0; i < NO_MEMS; i++) begin : g_ram
        adam_axil_ram #(
            .MEM_DEPTH (MEM_DEPTH)
        ) u_ram (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (mem_req[i]),
            .bus_req   (mem_bus_req),
            .ack       (mem_ack[i]),
            .bus_rsp   (mem_bus_rsp[i]),
            .pause_req (mem_pause_req[i]),
            .pause_ack (mem_pause_ack[i])
        );
    end

endmodule

`default_nettype wire

// ==== design/adam_pause_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module adam_pause_ctrl #(
    parameter int NO_MEMS = 3
) (
    input  wire logic clk,
    input  wire logic rst_n,

    input  wire logic pause_req,
    output logic      pause_ack,

    output logic      mem_pause_req [NO_MEMS],
    input  wire logic mem_pause_ack [NO_MEMS]
);

    import adam_ctrl_pkg::*;

    pause_state_t state;
    logic         all_ack;
    logic         all_low;
    logic         broadcast;

    always_comb begin
        all_ack = 1'b1;
        all_low = 1'b1;
        for (int i = 0; i < NO_MEMS; i++) begin
            all_ack = all_ack && mem_pause_ack[i];
            all_low = all_low && !mem_pause_ack[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUNNING;
        end else begin
            case (state)
                RUNNING: begin
                    if (pause_req) begin
                        state <= PAUSING;
                    end
                end
                PAUSING: begin
                    // Busy RAMs finish their access first.
                    if (all_ack) begin
                        state <= PAUSED;
                    end
                end
                PAUSED: begin
                    if (!pause_req) begin
                        state <= RESUMING;
                    end
                end
                RESUMING: begin
                    if (all_low) begin
                        state <= RUNNING;
                    end
                end
                default: begin
                    state <= RUNNING;
                end
            endcase
        end
    end

    assign broadcast = (state == PAUSING) || (state == PAUSED);
    assign pause_ack = (state == PAUSED) || (state == RESUMING);

    always_comb begin
        for (int i = 0; i < NO_MEMS; i++) begin
            mem_pause_req[i] = broadcast;
        end
    end

    // The system ack moves only after every RAM has moved.
    a_ack_merge: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(pause_ack) |-> $past(all_ack)) and ($fell(pause_ack) |-> $past(all_low)))
        else $error("pause_ack changed before all RAMs agreed");

endmodule

`default_nettype wire

// ==== design/adam_mem_demux.sv ====
`timescale 1ns/100ps
`default_nettype none

module adam_mem_demux #(
    parameter int NO_MEMS   = 3,
    parameter int MEM_DEPTH = 256
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   req,
    input  wire adam_bus_pkg::bus_req_t bus_req,
    output logic                        ack,
    output adam_bus_pkg::bus_rsp_t      bus_rsp,

    output logic                        mem_req     [NO_MEMS],
    output adam_bus_pkg::bus_req_t      mem_bus_req,
    input  wire logic                   mem_ack     [NO_MEMS],
    input  wire adam_bus_pkg::bus_rsp_t mem_bus_rsp [NO_MEMS]
);

    import adam_bus_pkg::*;

    localparam int SEL_W    = ADDR_WIDTH - MEM_SEL_LSB;
    localparam int BYTE_LSB = $clog2(STRB_WIDTH);
    localparam int OFF_W    = MEM_SEL_LSB - BYTE_LSB;

    logic [SEL_W-1:0] dec_sel;
    logic [OFF_W-1:0] word_off;
    logic             dec_err;
    logic             req_q;
    logic             req_rise;
    logic [SEL_W-1:0] tgt_sel_q;
    logic             tgt_err_q;
    logic [SEL_W-1:0] tgt_sel;
    logic             tgt_err;
    logic             err_ack_q;
    logic             mem_ack_sel;
    bus_rsp_t         mem_rsp_sel;

    assign dec_sel  = bus_req.addr[ADDR_WIDTH-1:MEM_SEL_LSB];
    assign word_off = bus_req.addr[MEM_SEL_LSB-1:BYTE_LSB];
    assign dec_err  = (dec_sel >= NO_MEMS) || (word_off >= MEM_DEPTH);

    assign req_rise = req && !req_q;

    // Live decode on the rising cycle, latched target until ack drops.
    assign tgt_sel = req_rise ? dec_sel : tgt_sel_q;
    assign tgt_err = req_rise ? dec_err : tgt_err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            tgt_sel_q <= '0;
            tgt_err_q <= 1'b0;
            err_ack_q <= 1'b0;
        end else begin
            req_q <= req;
            if (req_rise) begin
                tgt_sel_q <= dec_sel;
                tgt_err_q <= dec_err;
            end
            // Decode errors are answered here with the same latency as a RAM.
            err_ack_q <= req && tgt_err;
        end
    end

    always_comb begin
        mem_bus_req      = bus_req;
        mem_bus_req.addr = ADDR_WIDTH'(word_off);
    end

    always_comb begin
        mem_ack_sel = 1'b0;
        mem_rsp_sel = '0;
        for (int i = 0; i < NO_MEMS; i++) begin
            mem_req[i] = req && !tgt_err && (tgt_sel == SEL_W'(i));
            if (tgt_sel == SEL_W'(i)) begin
                mem_ack_sel = mem_ack[i];
                mem_rsp_sel = mem_bus_rsp[i];
            end
        end
    end

    assign ack     = tgt_err ? err_ack_q : mem_ack_sel;
    assign bus_rsp = tgt_err ? bus_rsp_t'{rdata: '0, err: 1'b1} : mem_rsp_sel;

    // Master keeps the payload steady for the whole req phase.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req && $past(req) |-> $stable(bus_req))
        else $error("bus_req changed while req was high");

endmodule

`default_nettype wire

// ==== design/adam_axil_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module adam_axil_ram #(
    parameter int MEM_DEPTH = 256
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire logic                 req,
    input  wire adam_bus_pkg::bus_req_t bus_req,
    output logic                      ack,
    output adam_bus_pkg::bus_rsp_t    bus_rsp,

    input  wire logic                 pause_req,
    output logic                      pause_ack
);

    import adam_bus_pkg::*;
    import adam_ctrl_pkg::*;

    localparam int OFF_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    access_state_t         state;
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [OFF_W-1:0]      offset;
    logic                  start;

    // The decoder already turned the byte address into a word offset.
    assign offset = bus_req.addr[OFF_W-1:0];

    // Pause wins over a request arriving at the same edge.
    assign start = (state == ACC_IDLE) && req && !pause_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACC_IDLE;
        end else begin
            case (state)
                ACC_IDLE: begin
                    if (pause_req) begin
                        state <= ACC_PAUSED;
                    end else if (req) begin
                        state <= ACC_ACK;
                    end
                end
                ACC_ACK: begin
                    if (!req) begin
                        state <= ACC_IDLE;
                    end
                end
                ACC_PAUSED: begin
                    // Requests stay pending here.
                    if (!pause_req) begin
                        state <= ACC_IDLE;
                    end
                end
                default: begin
                    state <= ACC_IDLE;
                end
            endcase
        end
    end

    // Byte-strobe write and registered read at the accepting edge.
    always_ff @(posedge clk) begin
        if (start) begin
            if (bus_req.write) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (bus_req.wstrb[b]) begin
                        mem[offset][8*b +: 8] <= bus_req.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[offset];
        end
    end

    assign ack       = (state == ACC_ACK);
    assign pause_ack = (state == ACC_PAUSED);
    assign bus_rsp   = '{rdata: rdata_q, err: 1'b0};

    // An ack only ever answers a request sampled one edge earlier.
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    // Pause is granted only from idle, never in the middle of a transaction.
    a_pause_not_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pause_ack) |-> $past(pause_req) && !$past(ack))
        else $error("pause_ack rose during an access");

endmodule

`default_nettype wire

// ==== design/adam_ctrl_pkg.sv ====
`default_nettype none

package adam_ctrl_pkg;

    // System pause sequencing.
    typedef enum logic [1:0] {
        RUNNING,
        PAUSING,
        PAUSED,
        RESUMING
    } pause_state_t;

    // Per-RAM access handshake.
    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_ACK,
        ACC_PAUSED
    } access_state_t;

endpackage

`default_nettype wire

// ==== design/adam_bus_pkg.sv ====
`default_nettype none

package adam_bus_pkg;

    // Fixed lite-bus widths.
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // One strobe bit per data byte.
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Memory index sits above this address bit.
    localparam int MEM_SEL_LSB = 16;

    // Access request, held stable by the master while req is high.
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  write;
    } bus_req_t;

    // Access response, valid while ack is high.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  err;
    } bus_rsp_t;

endpackage

`default_nettype wire
